// File: project.f
verilog/datapath_pkg.sv
verilog/pipe_delay.sv
verilog/operand_bank.sv
verilog/issue_control.sv
verilog/alu_stage.sv
verilog/datapath_top.sv
verification/datapath_tb.sv

// File: run.sh
#!/bin/sh
# Build the datapath testbench with Verilator, run it and check the log.
rm -f sim.log
verilator --binary --timing --assert --top-module datapath_tb -f project.f -o datapath_sim \
    && ./obj_dir/datapath_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: verification/datapath_tb.sv
`timescale 1ns/100ps
`default_nettype none

module datapath_tb;

    localparam int         CLK_PERIOD = 8;
    localparam int         WAIT_LIMIT = 16;
    localparam int         RAND_SEED  = 94593;
    localparam logic [5:0] IO_SRC     = 6'd63;
    localparam logic [7:0] A_PORT_D   = 8'd63;
    localparam logic [7:0] B_PORT_D   = 8'd127;

    // Expected port write: target bank, cycle of the strobe and data.
    typedef struct packed {
        logic                to_b;
        logic [31:0]         due;
        datapath_pkg::word_t data;
    } port_write_t;

    logic                  clock;
    logic                  rst_n;
    datapath_pkg::instr_t  instr;
    logic                  io_ready;
    datapath_pkg::io_in_t  a_in;
    datapath_pkg::io_in_t  b_in;
    logic                  a_rden;
    logic                  b_rden;
    logic                  a_full;
    logic                  b_full;
    datapath_pkg::io_out_t a_out;
    datapath_pkg::io_out_t b_out;

    // Reference model state.
    datapath_pkg::word_t model_a [64];
    datapath_pkg::word_t model_b [64];
    port_write_t         write_q [$];
    logic [31:0]         cycle;
    logic                issued;
    logic                exp_ready;
    logic                exp_a_wren;
    logic                exp_b_wren;
    datapath_pkg::word_t exp_a_data;
    datapath_pkg::word_t exp_b_data;

    string test_name;
    int    assert_errors = 0;
    int    first_error;
    int    wait_errors;
    int    tests_run;
    int    tests_failed;
    int    total_errors;

    datapath_top datapath_top_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .instr    (instr),
        .io_ready (io_ready),
        .a_in     (a_in),
        .b_in     (b_in),
        .a_rden   (a_rden),
        .b_rden   (b_rden),
        .a_full   (a_full),
        .b_full   (b_full),
        .a_out    (a_out),
        .b_out    (b_out)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // --------------------------------------------------
    // Reference model.
    // --------------------------------------------------

    function automatic logic op_defined(input logic [3:0] op);
        return (op >= datapath_pkg::ADD) && (op <= datapath_pkg::PASS_A);
    endfunction

    function automatic datapath_pkg::word_t expected_result(input logic [3:0] op,
                                                            input datapath_pkg::word_t x,
                                                            input datapath_pkg::word_t y);
        case (op)
            datapath_pkg::ADD: return x + y;
            datapath_pkg::SUB: return x - y;
            datapath_pkg::AND: return x & y;
            datapath_pkg::OR:  return x | y;
            datapath_pkg::XOR: return x ^ y;
            default:           return x;
        endcase
    endfunction

    // An instruction issues unless a port it touches cannot serve it.
    always_comb begin
        exp_ready = !((instr.a == IO_SRC && a_in.empty) || (instr.b == IO_SRC && b_in.empty)
                      || (instr.d == A_PORT_D && a_full) || (instr.d == B_PORT_D && b_full));
    end

    task automatic record_issue(input logic [31:0] due);
        datapath_pkg::word_t x;
        datapath_pkg::word_t y;
        datapath_pkg::word_t r;
        x = (instr.a == IO_SRC) ? a_in.data : model_a[instr.a];
        y = (instr.b == IO_SRC) ? b_in.data : model_b[instr.b];
        r = expected_result(instr.op, x, y);
        if (op_defined(instr.op)) begin
            if (instr.d == A_PORT_D || instr.d == B_PORT_D) begin
                write_q.push_back(port_write_t'{to_b: instr.d[6], due: due, data: r});
            end else if (instr.d < 8'd64) begin
                model_a[instr.d[5:0]] = r;
            end else if (instr.d < 8'd128) begin
                model_b[instr.d[5:0]] = r;
            end
        end
    endtask

    always @(posedge clock) begin
        if (!rst_n) begin
            cycle  = '0;
            issued = 1'b0;
            write_q.delete();
            for (int i = 0; i < 64; i++) begin
                model_a[i] = '0;
                model_b[i] = '0;
            end
        end else begin
            // The front entry was checked at this edge.
            if (write_q.size() > 0 && write_q[0].due == cycle) begin
                void'(write_q.pop_front());
            end
            // The sequencer follows the DUT's own io_ready.
            issued = io_ready;
            if (exp_ready) begin
                record_issue(cycle + 32'd2);
            end
            cycle = cycle + 32'd1;
        end
    end

    // Expected strobes for the current cycle, set away from the rising edge.
    always @(negedge clock) begin
        exp_a_wren = 1'b0;
        exp_b_wren = 1'b0;
        exp_a_data = '0;
        exp_b_data = '0;
        if (write_q.size() > 0 && write_q[0].due == cycle) begin
            if (write_q[0].to_b) begin
                exp_b_wren = 1'b1;
                exp_b_data = write_q[0].data;
            end else begin
                exp_a_wren = 1'b1;
                exp_a_data = write_q[0].data;
            end
        end
    end

    // --------------------------------------------------
    // Checks.
    // --------------------------------------------------

    task automatic log_mismatch(input string what, input datapath_pkg::word_t expected,
                                input datapath_pkg::word_t actual);
        assert_errors++;
        $display("FAIL %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    ready_a: assert property (@(posedge clock) disable iff (!rst_n) io_ready == exp_ready)
        else log_mismatch("io_ready", 16'(exp_ready), 16'($sampled(io_ready)));

    a_rden_a: assert property (@(posedge clock) disable iff (!rst_n)
        a_rden == (exp_ready && instr.a == IO_SRC))
        else log_mismatch("a_rden", 16'(exp_ready && instr.a == IO_SRC), 16'($sampled(a_rden)));

    b_rden_a: assert property (@(posedge clock) disable iff (!rst_n)
        b_rden == (exp_ready && instr.b == IO_SRC))
        else log_mismatch("b_rden", 16'(exp_ready && instr.b == IO_SRC), 16'($sampled(b_rden)));

    a_wren_a: assert property (@(posedge clock) disable iff (!rst_n) a_out.wren == exp_a_wren)
        else log_mismatch("a_out.wren", 16'(exp_a_wren), 16'($sampled(a_out.wren)));

    b_wren_a: assert property (@(posedge clock) disable iff (!rst_n) b_out.wren == exp_b_wren)
        else log_mismatch("b_out.wren", 16'(exp_b_wren), 16'($sampled(b_out.wren)));

    a_data_a: assert property (@(posedge clock) disable iff (!rst_n)
        a_out.wren |-> a_out.data == exp_a_data)
        else log_mismatch("a_out.data", exp_a_data, $sampled(a_out.data));

    b_data_a: assert property (@(posedge clock) disable iff (!rst_n)
        b_out.wren |-> b_out.data == exp_b_data)
        else log_mismatch("b_out.data", exp_b_data, $sampled(b_out.data));

    // --------------------------------------------------
    // Stimulus.
    // --------------------------------------------------

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic drive(input logic [3:0] op, input logic [7:0] d,
                         input logic [5:0] a, input logic [5:0] b);
        instr = '{op: op, d: d, a: a, b: b};
    endtask

    task automatic offer_ports();
        a_in = '{empty: 1'b0, data: 16'($urandom)};
        b_in = '{empty: 1'b0, data: 16'($urandom)};
    endtask

    // Reissue until accepted, then two idle cycles before the next instruction.
    task automatic wait_issue();
        int n;
        n = 0;
        step();
        while (!issued && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!issued) begin
            wait_errors++;
            $display("test %s: instruction was never issued", test_name);
        end
        instr = '0;
        a_in.empty = 1'b1;
        b_in.empty = 1'b1;
        repeat (2) step();
    endtask

    task automatic send(input logic [3:0] op, input logic [7:0] d,
                        input logic [5:0] a, input logic [5:0] b);
        drive(op, d, a, b);
        wait_issue();
    endtask

    task automatic drain_writes();
        int n;
        n = 0;
        while (write_q.size() > 0 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (write_q.size() > 0) begin
            wait_errors++;
            $display("test %s: expected port writes never arrived", test_name);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        wait_errors = 0;
        first_error = assert_errors;
    endtask

    task automatic end_test();
        int errors;
        drain_writes();
        step();
        errors = assert_errors - first_error + wait_errors;
        total_errors += errors;
        tests_run++;
        if (errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors);
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst_n        = 1'b0;
        instr        = '0;
        a_in         = '{empty: 1'b1, data: '0};
        b_in         = '{empty: 1'b1, data: '0};
        a_full       = 1'b0;
        b_full       = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;
        wait_errors  = 0;
        first_error  = 0;
        test_name    = "reset";
        repeat (3) @(posedge clock);
        #1;
        rst_n = 1'b1;

        start_test("after_reset");
        repeat (3) step();
        send(4'd7, A_PORT_D, 6'd1, 6'd2);
        send(4'd15, B_PORT_D, 6'd3, 6'd4);
        send(datapath_pkg::NOP, A_PORT_D, 6'd0, 6'd0);
        send(datapath_pkg::ADD, 8'd200, 6'd1, 6'd2);
        end_test();

        start_test("port_to_port");
        offer_ports();
        send(datapath_pkg::ADD, A_PORT_D, IO_SRC, IO_SRC);
        offer_ports();
        send(datapath_pkg::SUB, B_PORT_D, IO_SRC, IO_SRC);
        end_test();

        start_test("ram_all_ops");
        for (int i = 0; i < 4; i++) begin
            offer_ports();
            send(datapath_pkg::PASS_A, 8'(i), IO_SRC, 6'd0);
            offer_ports();
            send(datapath_pkg::PASS_A, 8'(64 + i), IO_SRC, 6'd0);
        end
        for (int op = 1; op <= 6; op++) begin
            send(4'(op), B_PORT_D, 6'(op % 4), 6'((op + 1) % 4));
        end
        // Dependent pair spaced by the read-after-write distance.
        send(datapath_pkg::XOR, 8'd10, 6'd0, 6'd1);
        send(datapath_pkg::PASS_A, A_PORT_D, 6'd10, 6'd0);
        end_test();

        start_test("empty_read");
        offer_ports();
        send(datapath_pkg::PASS_A, 8'd5, IO_SRC, 6'd0);
        a_in = '{empty: 1'b1, data: 16'($urandom)};
        drive(datapath_pkg::PASS_A, 8'd5, IO_SRC, 6'd0);
        repeat (2) step();
        b_in = '{empty: 1'b1, data: 16'($urandom)};
        drive(datapath_pkg::ADD, 8'd66, 6'd1, IO_SRC);
        repeat (2) step();
        instr = '0;
        repeat (2) step();
        send(datapath_pkg::PASS_A, A_PORT_D, 6'd5, 6'd0);
        // Bank B location 2 only reaches a port through an operation that reads B.
        send(datapath_pkg::XOR, B_PORT_D, 6'd2, 6'd2);
        end_test();

        start_test("full_write");
        a_full = 1'b1;
        drive(datapath_pkg::PASS_A, A_PORT_D, 6'd5, 6'd0);
        repeat (2) step();
        a_full = 1'b0;
        wait_issue();
        b_full = 1'b1;
        drive(datapath_pkg::OR, B_PORT_D, 6'd1, 6'd2);
        repeat (2) step();
        b_full = 1'b0;
        wait_issue();
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu_stage.sv
`timescale 1ns/100ps
`default_nettype none

module alu_stage #(
    parameter int ALU_DEPTH = 1
) (
    input  wire                            clock,
    input  wire                            rst_n,
    input  wire  datapath_pkg::alu_ctrl_t  ctrl,
    input  wire  datapath_pkg::word_t      a,
    input  wire  datapath_pkg::word_t      b,
    output datapath_pkg::wb_t              wb
);

    localparam datapath_pkg::wb_t WB_IDLE = '{valid: 1'b0, d: '0, result: '0};

    datapath_pkg::wb_t wb_next;

    // ------------------------------------------------
    // Result.
    // ------------------------------------------------

    // Add and subtract wrap at the word width.
    always_comb begin
        wb_next.valid  = 1'b1;
        wb_next.d      = ctrl.d;
        wb_next.result = '0;
        case (ctrl.op)
            datapath_pkg::ADD:    wb_next.result = a + b;
            datapath_pkg::SUB:    wb_next.result = a - b;
            datapath_pkg::AND:    wb_next.result = a & b;
            datapath_pkg::OR:     wb_next.result = a | b;
            datapath_pkg::XOR:    wb_next.result = a ^ b;
            datapath_pkg::PASS_A: wb_next.result = a;
            default: begin
                wb_next.valid = 1'b0;
            end
        endcase
    end

    // Result travels with D and valid to the banks.
    pipe_delay #(
        .T         (datapath_pkg::wb_t),
        .DEPTH     (ALU_DEPTH),
        .RESET_VAL (WB_IDLE)
    ) wb_pipe (
        .clock (clock),
        .rst_n (rst_n),
        .d     (wb_next),
        .q     (wb)
    );

    // Depth is set at the top level; zero would leave no writeback register.
    alu_depth_a: assert property (
        @(posedge clock) ALU_DEPTH >= 1
    ) else $error("ALU_DEPTH must be at least 1");

endmodule

`default_nettype wire

// File: verilog/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

    // ------------------------------------------------
    // Field widths.
    // ------------------------------------------------

    localparam int WORD_W  = 16;
    localparam int OP_W    = 4;
    localparam int D_W     = 8;
    localparam int S_W     = 6;
    localparam int INSTR_W = OP_W + D_W + 2 * S_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [D_W-1:0]    dest_t;
    typedef logic [S_W-1:0]    src_t;

    // Values not listed here execute as NOP.
    typedef enum logic [OP_W-1:0] {
        NOP    = 4'd0,
        ADD    = 4'd1,
        SUB    = 4'd2,
        AND    = 4'd3,
        OR     = 4'd4,
        XOR    = 4'd5,
        PASS_A = 4'd6
    } opcode_e;

    // ------------------------------------------------
    // Instruction and pipeline payloads.
    // ------------------------------------------------

    // Op in the high bits, then D, A and B.
    typedef struct packed {
        logic [OP_W-1:0] op;
        dest_t           d;
        src_t            a;
        src_t            b;
    } instr_t;

    typedef struct packed {
        opcode_e op;
        dest_t   d;
    } alu_ctrl_t;

    typedef struct packed {
        logic  valid;
        dest_t d;
        word_t result;
    } wb_t;

    // External FIFO ports.
    typedef struct packed {
        logic  empty;
        word_t data;
    } io_in_t;

    typedef struct packed {
        logic  wren;
        word_t data;
    } io_out_t;

endpackage

`default_nettype wire

// File: verilog/datapath_top.sv
`timescale 1ns/100ps
`default_nettype none

module datapath_top #(
    parameter int BANK_DEPTH   = 64,
    parameter int A_WRITE_BASE = 0,
    parameter int B_WRITE_BASE = 64,
    parameter int IO_ADDR      = 63,
    parameter int ALU_DEPTH    = 1
) (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire  datapath_pkg::instr_t  instr,
    output logic                        io_ready,
    input  wire  datapath_pkg::io_in_t  a_in,
    input  wire  datapath_pkg::io_in_t  b_in,
    output logic                        a_rden,
    output logic                        b_rden,
    input  wire                         a_full,
    input  wire                         b_full,
    output datapath_pkg::io_out_t       a_out,
    output datapath_pkg::io_out_t       b_out
);

    logic                    issue;
    logic                    a_blocked;
    logic                    b_blocked;
    datapath_pkg::alu_ctrl_t ctrl;
    datapath_pkg::word_t     a_operand;
    datapath_pkg::word_t     b_operand;
    datapath_pkg::wb_t       wb;

    // ------------------------------------------------
    // Issue.
    // ------------------------------------------------

    issue_control issue_ctl (
        .clock     (clock),
        .rst_n     (rst_n),
        .instr     (instr),
        .a_blocked (a_blocked),
        .b_blocked (b_blocked),
        .io_ready  (io_ready),
        .issue     (issue),
        .ctrl      (ctrl)
    );

    // ------------------------------------------------
    // Banks. Both see the full D field and writeback.
    // ------------------------------------------------

    operand_bank #(
        .BANK_DEPTH (BANK_DEPTH),
        .WRITE_BASE (A_WRITE_BASE),
        .IO_ADDR    (IO_ADDR)
    ) bank_a (
        .clock    (clock),
        .rst_n    (rst_n),
        .addr     (instr.a),
        .dest     (instr.d),
        .issue    (issue),
        .port_in  (a_in),
        .rden     (a_rden),
        .full     (a_full),
        .wb       (wb),
        .port_out (a_out),
        .blocked  (a_blocked),
        .operand  (a_operand)
    );

    operand_bank #(
        .BANK_DEPTH (BANK_DEPTH),
        .WRITE_BASE (B_WRITE_BASE),
        .IO_ADDR    (IO_ADDR)
    ) bank_b (
        .clock    (clock),
        .rst_n    (rst_n),
        .addr     (instr.b),
        .dest     (instr.d),
        .issue    (issue),
        .port_in  (b_in),
        .rden     (b_rden),
        .full     (b_full),
        .wb       (wb),
        .port_out (b_out),
        .blocked  (b_blocked),
        .operand  (b_operand)
    );

    alu_stage #(
        .ALU_DEPTH (ALU_DEPTH)
    ) alu (
        .clock (clock),
        .rst_n (rst_n),
        .ctrl  (ctrl),
        .a     (a_operand),
        .b     (b_operand),
        .wb    (wb)
    );

endmodule

`default_nettype wire

// File: verilog/issue_control.sv
`timescale 1ns/100ps
`default_nettype none

module issue_control (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire  datapath_pkg::instr_t  instr,
    input  wire                         a_blocked,
    input  wire                         b_blocked,
    output logic                        io_ready,
    output logic                        issue,
    output datapath_pkg::alu_ctrl_t     ctrl
);

    localparam datapath_pkg::alu_ctrl_t CTRL_NOP = '{op: datapath_pkg::NOP, d: '0};

    logic                    op_defined;
    datapath_pkg::alu_ctrl_t ctrl_next;

    // ------------------------------------------------
    // Decode and annul.
    // ------------------------------------------------

    assign op_defined = instr.op inside {[datapath_pkg::ADD:datapath_pkg::PASS_A]};

    // The sequencer sees io_ready low and reissues later.
    assign io_ready = !(a_blocked || b_blocked);
    assign issue    = io_ready;

    always_comb begin
        if (issue && op_defined) begin
            ctrl_next.op = datapath_pkg::opcode_e'(instr.op);
            ctrl_next.d  = instr.d;
        end else begin
            ctrl_next = CTRL_NOP;
        end
    end

    // One stage, so op and D line up with the bank operand registers.
    pipe_delay #(
        .T         (datapath_pkg::alu_ctrl_t),
        .DEPTH     (1),
        .RESET_VAL (CTRL_NOP)
    ) ctrl_pipe (
        .clock (clock),
        .rst_n (rst_n),
        .d     (ctrl_next),
        .q     (ctrl)
    );

endmodule

`default_nettype wire

// File: verilog/operand_bank.sv
`timescale 1ns/100ps
`default_nettype none

module operand_bank #(
    parameter int BANK_DEPTH = 64,
    parameter int WRITE_BASE = 0,
    parameter int IO_ADDR    = 63
) (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire  datapath_pkg::src_t    addr,
    input  wire  datapath_pkg::dest_t   dest,
    input  wire                         issue,
    input  wire  datapath_pkg::io_in_t  port_in,
    output logic                        rden,
    input  wire                         full,
    input  wire  datapath_pkg::wb_t     wb,
    output datapath_pkg::io_out_t       port_out,
    output logic                        blocked,
    output datapath_pkg::word_t         operand
);

    localparam int ADDR_W = $clog2(BANK_DEPTH);

    datapath_pkg::word_t ram [BANK_DEPTH];

    logic                read_is_io;
    logic                dest_is_io;
    logic                wb_hit;
    logic                wb_is_io;
    datapath_pkg::dest_t wb_offset;

    // ------------------------------------------------
    // Issue side.
    // ------------------------------------------------

    assign read_is_io = (addr == datapath_pkg::src_t'(IO_ADDR));
    assign dest_is_io = (dest == datapath_pkg::dest_t'(WRITE_BASE + IO_ADDR));

    // An empty read port or a full write port holds the instruction back.
    assign blocked = (read_is_io && port_in.empty) || (dest_is_io && full);

    assign rden = issue && read_is_io;

    // Registered read. The port word is taken at the same edge as rden.
    always_ff @(posedge clock) begin
        if (issue) begin
            if (read_is_io) begin
                operand <= port_in.data;
            end else begin
                operand <= ram[addr[ADDR_W-1:0]];
            end
        end
    end

    // ------------------------------------------------
    // Writeback side.
    // ------------------------------------------------

    // Only D values inside this bank's window are claimed.
    assign wb_hit = wb.valid
                    && (int'(wb.d) >= WRITE_BASE)
                    && (int'(wb.d) < WRITE_BASE + BANK_DEPTH);

    assign wb_offset = wb.d - datapath_pkg::dest_t'(WRITE_BASE);
    assign wb_is_io  = (wb_offset == datapath_pkg::dest_t'(IO_ADDR));

    always_ff @(posedge clock) begin
        if (wb_hit && !wb_is_io) begin
            ram[wb_offset[ADDR_W-1:0]] <= wb.result;
        end
    end

    // The I/O location bypasses the RAM.
    assign port_out.wren = wb_hit && wb_is_io;
    assign port_out.data = wb.result;

    // Issue comes back from the control block, so this checks the loop.
    rden_not_empty_a: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(rden && port_in.empty)
    ) else $error("read strobe raised on an empty port");

endmodule

`default_nettype wire

// File: verilog/pipe_delay.sv
`timescale 1ns/100ps
`default_nettype none

// Shift register of DEPTH stages for any packed payload.
module pipe_delay #(
    parameter type T         = logic,
    parameter int  DEPTH     = 1,
    parameter T    RESET_VAL = '0
) (
    input  wire  clock,
    input  wire  rst_n,
    input  wire  T d,
    output T     q
);

    T stage [DEPTH];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= RESET_VAL;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

`default_nettype wire
